// File: icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ************************************************************
// address and line geometry
// ************************************************************
`define ICACHE_ADDR_W      64
`define ICACHE_WORD_W      64
`define ICACHE_SETS        64
`define ICACHE_INDEX_W     6
`define ICACHE_WAYS        2
`define ICACHE_LINE_W      128
`define ICACHE_OFFSET_W    4
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// request and response queues
`define ICACHE_FIFO_DEPTH  4

// ************************************************************
// AXI side
// ************************************************************
`define ICACHE_AXI_ID      3
`define ICACHE_AXI_ID_W    4

// cacheable memory window, bounds inclusive
`define ICACHE_PMEM_START  64'h0000_0000_8000_0000
`define ICACHE_PMEM_END    64'h0000_0000_ffff_ffff

`endif

// File: axi_rd_pkg.sv
`include "icache_params.svh"

package axi_rd_pkg;

    // read response codes, exokay never used here
    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2,
        resp_decerr = 2'd3
    } resp_code_e;

    // read address channel payload
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0]   addr;
        logic [`ICACHE_AXI_ID_W-1:0] id;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        logic [`ICACHE_WORD_W-1:0]   data;
        resp_code_e                  resp;
        logic                        last;
        logic [`ICACHE_AXI_ID_W-1:0] id;
    } axi_r_t;

endpackage

// File: icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    import axi_rd_pkg::*;

    // one word back to the fetch unit
    typedef struct packed {
        resp_code_e                resp;
        logic [`ICACHE_WORD_W-1:0] data;
    } fetch_resp_t;

    // registered lookup result of the array stage
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic                      hit;
        logic [`ICACHE_WORD_W-1:0] word;
        logic                      valid;
    } lookup_t;

    // line write from the refill FSM
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [`ICACHE_LINE_W-1:0] line;
        logic                      way;
        logic                      we;
    } refill_t;

    // ************************************************************
    // refill FSM states
    // ************************************************************
    typedef enum logic [2:0] {
        st_idle  = 3'b000,
        st_addr  = 3'b010,
        st_beat0 = 3'b110,
        st_beat1 = 3'b111,
        st_write = 3'b101,
        st_send  = 3'b100
    } refill_state_e;

endpackage

// File: fetch_fifo.sv
module fetch_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: icache_array.sv
`include "icache_params.svh"

module icache_array (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      invalidate,
    input  logic                      req_valid,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr,
    output logic                      req_pop,
    input  logic                      advance,
    output icache_pkg::lookup_t       lookup,
    input  icache_pkg::refill_t       refill
);

    localparam int WORD_SEL = `ICACHE_OFFSET_W - 1;

    // behavioral line storage
    logic [`ICACHE_TAG_W-1:0]  tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_LINE_W-1:0] data_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;

    // lookup stage
    logic                      stage_valid;
    logic [`ICACHE_ADDR_W-1:0] stage_addr;
    logic [`ICACHE_TAG_W-1:0]  stage_tag  [`ICACHE_WAYS];
    logic [`ICACHE_LINE_W-1:0] stage_line [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]   stage_line_valid;

    logic [`ICACHE_INDEX_W-1:0] rd_index;
    logic [`ICACHE_INDEX_W-1:0] wr_index;
    logic [`ICACHE_WAYS-1:0]    way_hit;
    logic [`ICACHE_LINE_W-1:0]  hit_line;

    assign rd_index = req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wr_index = refill.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // take a new request when the stage is free or being drained
    assign req_pop = req_valid && (!stage_valid || advance);

    // ************************************************************
    // array update
    // ************************************************************
    always_ff @(posedge clk) begin
        if (refill.we) begin
            tag_mem[refill.way][wr_index]  <= refill.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
            data_mem[refill.way][wr_index] <= refill.line;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (invalidate) begin
            valid_q <= '0;
        end else if (refill.we) begin
            valid_q[refill.way][wr_index] <= 1'b1;
        end
    end

    // ************************************************************
    // stage register
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid      <= 1'b0;
            stage_line_valid <= '0;
        end else begin
            if (!stage_valid || advance) begin
                stage_valid <= req_valid;
            end
            // invalidate also kills a lookup already in flight
            if (invalidate) begin
                stage_line_valid <= '0;
            end else if (req_pop) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    stage_line_valid[w] <= valid_q[w][rd_index];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            stage_addr <= req_addr;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                stage_tag[w]  <= tag_mem[w][rd_index];
                stage_line[w] <= data_mem[w][rd_index];
            end
        end
    end

    // tag compare, lowest matching way wins
    always_comb begin
        hit_line = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            way_hit[w] = stage_line_valid[w] &&
                         (stage_tag[w] == stage_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W]);
            if (way_hit[w]) begin
                hit_line = stage_line[w];
            end
        end
    end

    always_comb begin
        lookup.addr  = stage_addr;
        lookup.hit   = |way_hit;
        lookup.word  = hit_line[stage_addr[WORD_SEL] * `ICACHE_WORD_W +: `ICACHE_WORD_W];
        lookup.valid = stage_valid;
    end

endmodule

// File: victim_way_lfsr.sv
module victim_way_lfsr (
    input  logic clk,
    input  logic rst_n,
    output logic way
);

    localparam logic [7:0] SEED = 8'h01;

    logic [7:0] lfsr_q;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= SEED;
        end else begin
            lfsr_q <= {lfsr_q[6:0], feedback};
        end
    end

    assign way = lfsr_q[0];

endmodule

// File: icache_refill_fsm.sv
`include "icache_params.svh"

module icache_refill_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      miss_valid,
    input  logic [`ICACHE_ADDR_W-1:0] miss_addr,
    input  logic                      victim,
    output logic                      m_arvalid,
    input  logic                      m_arready,
    output axi_rd_pkg::axi_ar_t       m_ar,
    input  logic                      m_rvalid,
    input  axi_rd_pkg::axi_r_t        m_r,
    output icache_pkg::refill_t       refill,
    output logic                      send_valid,
    input  logic                      send_ready,
    output icache_pkg::fetch_resp_t   send_data
);

    import axi_rd_pkg::*;
    import icache_pkg::*;

    localparam logic [`ICACHE_AXI_ID_W-1:0] AXI_ID = `ICACHE_AXI_ID;
    localparam int WORD_SEL = `ICACHE_OFFSET_W - 1;

    refill_state_e             state_q;
    refill_state_e             state_d;
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    logic [`ICACHE_LINE_W-1:0] line_q;
    logic                      victim_q;
    resp_code_e                resp_q;
    logic                      beat_ok;
    logic                      cacheable;
    logic                      fill_ok;

    // beats with a foreign id belong to someone else
    assign beat_ok   = m_rvalid && (m_r.id == AXI_ID);
    assign cacheable = (addr_q >= `ICACHE_PMEM_START) && (addr_q <= `ICACHE_PMEM_END);
    assign fill_ok   = cacheable && (resp_q == resp_okay) && (m_r.resp == resp_okay);

    // ************************************************************
    // state machine
    // ************************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (miss_valid) begin
                    state_d = st_addr;
                end
            end
            st_addr: begin
                if (m_arready) begin
                    state_d = st_beat0;
                end
            end
            st_beat0: begin
                if (beat_ok) begin
                    state_d = st_beat1;
                end
            end
            st_beat1: begin
                if (beat_ok) begin
                    state_d = fill_ok ? st_write : st_send;
                end
            end
            st_write: begin
                state_d = st_send;
            end
            st_send: begin
                if (send_ready) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            resp_q  <= resp_okay;
        end else begin
            state_q <= state_d;
            if (state_q == st_idle && miss_valid) begin
                resp_q <= resp_okay;
            end else if ((state_q == st_beat0 || state_q == st_beat1) && beat_ok &&
                         resp_q == resp_okay) begin
                // keep only the first error of the burst
                resp_q <= m_r.resp;
            end
        end
    end

    // miss capture and line assembly
    always_ff @(posedge clk) begin
        if (state_q == st_idle && miss_valid) begin
            addr_q   <= miss_addr;
            victim_q <= victim;
        end
        if (state_q == st_beat0 && beat_ok) begin
            line_q[`ICACHE_WORD_W-1:0] <= m_r.data;
        end
        if (state_q == st_beat1 && beat_ok) begin
            line_q[`ICACHE_LINE_W-1 -: `ICACHE_WORD_W] <= m_r.data;
        end
    end

    // ************************************************************
    // outputs
    // ************************************************************
    assign m_arvalid = (state_q == st_addr);

    always_comb begin
        m_ar.addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        m_ar.id   = AXI_ID;
    end

    always_comb begin
        refill.addr = addr_q;
        refill.line = line_q;
        refill.way  = victim_q;
        refill.we   = (state_q == st_write);
    end

    assign send_valid = (state_q == st_send);

    always_comb begin
        send_data.resp = resp_q;
        send_data.data = line_q[addr_q[WORD_SEL] * `ICACHE_WORD_W +: `ICACHE_WORD_W];
    end

endmodule

// File: icache_top.sv
`include "icache_params.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      invalidate,
    input  logic                      ifu_arvalid,
    output logic                      ifu_arready,
    input  logic [`ICACHE_ADDR_W-1:0] ifu_araddr,
    output logic                      ifu_rvalid,
    input  logic                      ifu_rready,
    output icache_pkg::fetch_resp_t   ifu_rdata,
    output logic                      m_arvalid,
    input  logic                      m_arready,
    output axi_rd_pkg::axi_ar_t       m_ar,
    input  logic                      m_rvalid,
    input  axi_rd_pkg::axi_r_t        m_r
);

    import axi_rd_pkg::*;
    import icache_pkg::*;

    logic                      req_full;
    logic                      req_empty;
    logic                      req_pop;
    logic [`ICACHE_ADDR_W-1:0] req_addr;

    lookup_t                   lookup;
    refill_t                   refill;
    logic                      victim;
    logic                      miss_valid;
    logic                      hit_push;
    logic                      advance;

    logic                      send_valid;
    logic                      send_ready;
    fetch_resp_t               send_data;

    logic                      resp_push;
    logic                      resp_full;
    logic                      resp_empty;
    fetch_resp_t               resp_data;

    // ************************************************************
    // request side
    // ************************************************************
    assign ifu_arready = !req_full;

    fetch_fifo #(
        .WIDTH (`ICACHE_ADDR_W),
        .DEPTH (`ICACHE_FIFO_DEPTH)
    ) u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ifu_arvalid && ifu_arready),
        .push_data (ifu_araddr),
        .full      (req_full),
        .pop       (req_pop),
        .pop_data  (req_addr),
        .empty     (req_empty)
    );

    icache_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .invalidate (invalidate),
        .req_valid  (!req_empty),
        .req_addr   (req_addr),
        .req_pop    (req_pop),
        .advance    (advance),
        .lookup     (lookup),
        .refill     (refill)
    );

    victim_way_lfsr u_victim (
        .clk   (clk),
        .rst_n (rst_n),
        .way   (victim)
    );

    // ************************************************************
    // miss handling
    // ************************************************************
    // stage holds the missed request until its answer is queued
    assign miss_valid = lookup.valid && !lookup.hit;

    icache_refill_fsm u_refill (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss_valid (miss_valid),
        .miss_addr  (lookup.addr),
        .victim     (victim),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .m_ar       (m_ar),
        .m_rvalid   (m_rvalid),
        .m_r        (m_r),
        .refill     (refill),
        .send_valid (send_valid),
        .send_ready (send_ready),
        .send_data  (send_data)
    );

    // ************************************************************
    // response side
    // ************************************************************
    assign send_ready = !resp_full;
    assign hit_push   = lookup.valid && lookup.hit && !resp_full;
    assign resp_push  = hit_push || (send_valid && send_ready);
    assign advance    = resp_push;

    // hit and refill answers never overlap, refill has a miss in the stage
    always_comb begin
        if (send_valid) begin
            resp_data = send_data;
        end else begin
            resp_data.resp = resp_okay;
            resp_data.data = lookup.word;
        end
    end

    fetch_fifo #(
        .WIDTH ($bits(fetch_resp_t)),
        .DEPTH (`ICACHE_FIFO_DEPTH)
    ) u_resp_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (resp_push),
        .push_data (resp_data),
        .full      (resp_full),
        .pop       (ifu_rvalid && ifu_rready),
        .pop_data  (ifu_rdata),
        .empty     (resp_empty)
    );

    assign ifu_rvalid = !resp_empty;

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a rising edge like any other driven input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: icache_assertions.sv
module icache_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    ifu_rvalid,
    input logic                    ifu_rready,
    input icache_pkg::fetch_resp_t ifu_rdata,
    input logic                    m_arvalid,
    input logic                    m_arready,
    input axi_rd_pkg::axi_ar_t     m_ar
);

    // counts failed assertions for the testbench
    int failures = 0;

    // ************************************************************
    // valid holds with its payload until the transfer
    // ************************************************************
    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata))
    else begin
        failures++;
        $error("fetch response dropped or changed before it was taken");
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar))
    else begin
        failures++;
        $error("AXI read address dropped or changed before arready");
    end

    // one address phase per burst
    ar_once: assert property (@(posedge clk) disable iff (!rst_n)
        m_arvalid && m_arready |=> !m_arvalid)
    else begin
        failures++;
        $error("AXI read address still valid after it was accepted");
    end

endmodule

bind icache_top icache_assertions u_handshake_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .ifu_rvalid (ifu_rvalid),
    .ifu_rready (ifu_rready),
    .ifu_rdata  (ifu_rdata),
    .m_arvalid  (m_arvalid),
    .m_arready  (m_arready),
    .m_ar       (m_ar)
);

// File: tb_icache.sv
`include "icache_params.svh"

module tb_icache;

    import axi_rd_pkg::*;
    import icache_pkg::*;

    localparam int ADDR_W         = `ICACHE_ADDR_W;
    localparam int ROUNDS         = 6;
    localparam int REQS_PER_ROUND = 60;
    localparam int CYCLE_LIMIT    = 400 * ROUNDS * REQS_PER_ROUND;
    localparam int POOL_SIZE      = 9;
    localparam logic [ADDR_W-1:0] DATA_KEY   = 64'h5a5a_c3c3_0f0f_9696;
    localparam logic [ADDR_W-1:0] ERROR_LINE = 64'h0000_0000_8000_0460;
    localparam logic [`ICACHE_AXI_ID_W-1:0] AXI_ID     = `ICACHE_AXI_ID;
    localparam logic [`ICACHE_AXI_ID_W-1:0] FOREIGN_ID = 4'd5;

    logic              clk;
    logic              rst_n;
    logic              invalidate;
    logic              ifu_arvalid;
    logic              ifu_arready;
    logic [ADDR_W-1:0] ifu_araddr;
    logic              ifu_rvalid;
    logic              ifu_rready;
    fetch_resp_t       ifu_rdata;
    logic              m_arvalid;
    logic              m_arready;
    axi_ar_t           m_ar;
    logic              m_rvalid;
    axi_r_t            m_r;

    // model and stimulus state
    logic [31:0]          rng_state;
    fetch_resp_t          exp_q[$];
    logic [ADDR_W-1:0]    exp_ar_q[$];
    logic [POOL_SIZE-1:0] present;
    logic                 req_pending;
    int                   req_idx;
    int                   issue_left;
    int                   stall_left;
    int                   cycle_count;
    logic                 burst_active;
    logic [ADDR_W-1:0]    burst_addr;
    logic                 beat_idx;
    int                   beat_wait;
    logic                 saw_arready_low;
    int                   hit_count;
    int                   error_count;

    tb_clk_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    icache_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .invalidate  (invalidate),
        .ifu_arvalid (ifu_arvalid),
        .ifu_arready (ifu_arready),
        .ifu_araddr  (ifu_araddr),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .ifu_rdata   (ifu_rdata),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .m_ar        (m_ar),
        .m_rvalid    (m_rvalid),
        .m_r         (m_r)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {16'h0000, rng_state[30:15]};
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return lcg_next() % n;
    endfunction

    // every pool line sits in its own set, so hit or miss is exact
    function automatic logic [ADDR_W-1:0] pool_line(input int idx);
        case (idx)
            0:       return 64'h0000_0000_8000_0000;
            1:       return 64'h0000_0000_8000_1010;
            2:       return 64'h0000_0000_8002_0020;
            3:       return 64'h0000_0000_9000_0030;
            4:       return 64'h0000_0000_a000_0040;
            5:       return 64'h0000_0000_ffff_fc50;
            6:       return ERROR_LINE;
            7:       return 64'h0000_0000_4000_0070;
            default: return 64'h0000_0001_0000_0080;
        endcase
    endfunction

    function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:4], 4'h0};
    endfunction

    // word address is the byte address with the low three bits cleared
    function automatic logic [ADDR_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:3], 3'b000} ^ DATA_KEY;
    endfunction

    function automatic logic is_error_line(input logic [ADDR_W-1:0] addr);
        return line_of(addr) == ERROR_LINE;
    endfunction

    function automatic logic is_cacheable(input logic [ADDR_W-1:0] addr);
        return (addr >= `ICACHE_PMEM_START) && (addr <= `ICACHE_PMEM_END);
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        fail_run($sformatf("mismatch at time %0t: %s", $time, what));
    endtask

    // ************************************************************
    // checks on accepted transfers
    // ************************************************************
    task automatic accept_request();
        fetch_resp_t exp;
        exp.data = model_word(ifu_araddr);
        exp.resp = is_error_line(ifu_araddr) ? resp_slverr : resp_okay;
        exp_q.push_back(exp);
        req_pending = 1'b0;
        if (present[req_idx]) begin
            hit_count++;
        end else begin
            exp_ar_q.push_back(line_of(ifu_araddr));
        end
        // only error-free lines inside the window stay behind
        if (is_cacheable(ifu_araddr) && !is_error_line(ifu_araddr)) begin
            present[req_idx] = 1'b1;
        end
    endtask

    task automatic check_response();
        fetch_resp_t exp;
        assert (exp_q.size() != 0) else
            fail_run("a fetch response arrived with no request outstanding");
        exp = exp_q.pop_front();
        if (exp.resp == resp_slverr) begin
            error_count++;
        end
        assert (ifu_rdata == exp) else
            report_mismatch($sformatf("fetch data %h resp %0d, expected data %h resp %0d",
                                      ifu_rdata.data, ifu_rdata.resp, exp.data, exp.resp));
    endtask

    task automatic check_read_address();
        logic [ADDR_W-1:0] exp_addr;
        assert (exp_ar_q.size() != 0) else
            fail_run($sformatf("AXI read of %h issued for a fetch that should hit", m_ar.addr));
        assert (!burst_active) else
            fail_run("AXI read issued before the previous burst finished");
        exp_addr = exp_ar_q.pop_front();
        assert (m_ar.addr == exp_addr && m_ar.id == AXI_ID) else
            report_mismatch($sformatf("AXI read addr %h id %0d, expected addr %h id %0d",
                                      m_ar.addr, m_ar.id, exp_addr, AXI_ID));
        burst_active = 1'b1;
        burst_addr   = m_ar.addr;
        beat_idx     = 1'b0;
        beat_wait    = int'(rand_below(4));
    endtask

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic drive_fetch();
        logic [31:0] rnd;
        rnd = lcg_next();
        if (!ifu_arvalid || ifu_arready) begin
            if (issue_left > 0 && rnd[1:0] != 2'b00) begin
                // a third of the time stay on the last line
                if (rand_below(3) != 0) begin
                    req_idx = int'(rand_below(POOL_SIZE));
                end
                ifu_arvalid <= 1'b1;
                ifu_araddr  <= pool_line(req_idx) | {60'h0, rnd[7:4]};
                req_pending = 1'b1;
                issue_left--;
            end else begin
                ifu_arvalid <= 1'b0;
            end
        end
        if (stall_left > 0) begin
            stall_left--;
            ifu_rready <= 1'b0;
        end else if (rand_below(16) == 0) begin
            // long stall backs up the whole pipe
            stall_left = 4 + int'(rand_below(24));
            ifu_rready <= 1'b0;
        end else begin
            ifu_rready <= (rand_below(6) != 0);
        end
    endtask

    // slave memory, beat data is its own address xor a key
    task automatic drive_axi();
        axi_r_t beat;
        m_arready <= (rand_below(3) != 0);
        beat.data = {lcg_next(), lcg_next()};
        beat.resp = resp_okay;
        beat.last = 1'b0;
        beat.id   = FOREIGN_ID;
        if (burst_active && beat_wait == 0) begin
            beat.data = (burst_addr | {60'h0, beat_idx, 3'b000}) ^ DATA_KEY;
            beat.resp = is_error_line(burst_addr) ? resp_slverr : resp_okay;
            beat.last = beat_idx;
            beat.id   = AXI_ID;
            m_rvalid <= 1'b1;
            m_r      <= beat;
            if (beat_idx) begin
                burst_active = 1'b0;
            end else begin
                beat_idx  = 1'b1;
                beat_wait = int'(rand_below(3));
            end
        end else begin
            if (burst_active) begin
                beat_wait--;
            end
            // stray beats for another master
            m_rvalid <= (rand_below(8) == 0);
            m_r      <= beat;
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        cycle_count++;
        assert (cycle_count <= CYCLE_LIMIT) else
            fail_run($sformatf("timeout: run still busy after %0d cycles", cycle_count));
        assert (dut.u_handshake_chk.failures == 0) else
            fail_run("a handshake assertion inside icache_top failed");
        if (!ifu_arready) begin
            saw_arready_low = 1'b1;
        end
        if (ifu_arvalid && ifu_arready) begin
            accept_request();
        end
        if (ifu_rvalid && ifu_rready) begin
            check_response();
        end
        if (m_arvalid && m_arready) begin
            check_read_address();
        end
        drive_fetch();
        drive_axi();
    endtask

    task automatic pulse_invalidate();
        invalidate <= 1'b1;
        step_cycle();
        invalidate <= 1'b0;
        present = '0;
    endtask

    initial begin
        invalidate      = 1'b0;
        ifu_arvalid     = 1'b0;
        ifu_araddr      = '0;
        ifu_rready      = 1'b0;
        m_arready       = 1'b0;
        m_rvalid        = 1'b0;
        m_r             = '0;
        rng_state       = 32'd17093;
        present         = '0;
        req_pending     = 1'b0;
        req_idx         = 0;
        issue_left      = 0;
        stall_left      = 0;
        cycle_count     = 0;
        burst_active    = 1'b0;
        burst_addr      = '0;
        beat_idx        = 1'b0;
        beat_wait       = 0;
        saw_arready_low = 1'b0;
        hit_count       = 0;
        error_count     = 0;

        do begin
            @(posedge clk);
        end while (!rst_n);
        assert (!ifu_rvalid && !m_arvalid && ifu_arready) else
            fail_run("cache is not idle after reset");

        // each round ends quiet, then every line is invalidated
        for (int round = 0; round < ROUNDS; round++) begin
            issue_left = REQS_PER_ROUND;
            while (issue_left > 0 || req_pending || exp_q.size() != 0) begin
                step_cycle();
            end
            pulse_invalidate();
        end

        assert (exp_ar_q.size() == 0) else
            fail_run("a fetch that should miss never issued its AXI read");
        assert (saw_arready_low) else
            fail_run("ifu_arready never dropped under response back-pressure");
        assert (hit_count > 0 && error_count > 0) else
            fail_run("stimulus produced no cache hits or no error responses");
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
axi_rd_pkg.sv
icache_pkg.sv
fetch_fifo.sv
icache_array.sv
victim_way_lfsr.sv
icache_refill_fsm.sv
icache_top.sv
tb_clk_gen.sv
icache_assertions.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache -f project.f -o sim_icache

result=$(./obj_dir/sim_icache 2>&1) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'TB PASSED'; then
    exit 0
fi
exit 1
